// File: build.f
+incdir+common
common/gbx_pkg.sv
hw/pad_router.sv
hw/ffwd_latch.sv
backup/backup_trigger.sv
backup/backup_seq.sv
hw/gbx_ctrl_top.sv
bench/tb_top.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
	-f build.f --top-module tb_top --Mdir obj_dir -o tb_top_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

out=$(./obj_dir/tb_top_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qF "Test completed successfully"; then
	exit 0
fi
exit 1

// File: bench/tb_top.sv
////////////////////////////////////////////////////////////////////////////
// Directed testbench for the console glue top level
// The SD host model acks after 2 to 6 cycles and moves 256 words a block.
// Backup RAM reads are modeled as combinational from bk_addr.
////////////////////////////////////////////////////////////////////////////
module tb_top;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int RESET_CYCLES   = 16;
	localparam int PAD_CYCLES     = 60;
	localparam int FF_CYCLES      = 400;
	localparam int BLOCK_CYCLES   = 256 + 6 + 4;
	localparam int XFER_BLOCKS    = 16;
	localparam int SETUP_CYCLES   = 200;
	localparam int TIMEOUT_CYCLES = 2 * (RESET_CYCLES + PAD_CYCLES + FF_CYCLES +
		XFER_BLOCKS * BLOCK_CYCLES + SETUP_CYCLES);

	logic clk_sys;
	logic reset;
	gbx_pkg::joy_t       usb_0, usb_1, usb_2, usb_3;
	gbx_pkg::pad_btn_t   pad_a_btn, pad_b_btn;
	gbx_pkg::pad_type_t  pad_a_type, pad_b_type;
	logic                pad_a_en, pad_b_en, native_sel;
	gbx_pkg::joy_t       joy_0, joy_1, joy_2, joy_3;
	logic                osd_combo, download_busy, osd_open, ff_active;
	logic                cart_loading, img_mounted, img_readonly, img_nonempty;
	logic                cart_has_save, cram_wr, autosave_en, load_cmd, save_cmd;
	logic                sav_pending, rtc_inuse, bk_wr, bk_rtc_wr, bk_loading, seq_done;
	gbx_pkg::blk_t       ram_mask;
	gbx_pkg::rtc_stamp_t rtc_stamp;
	gbx_pkg::rtc_saved_t rtc_saved;
	gbx_pkg::sd_word_t   bk_q, bk_data, sd_buff_dout, sd_buff_din;
	gbx_pkg::bk_addr_t   bk_addr;
	gbx_pkg::lba_t       sd_lba;
	logic                sd_rd, sd_wr, sd_ack, sd_buff_wr;
	gbx_pkg::buf_addr_t  sd_buff_addr;

	int   error_count = 0;
	int   check_count = 0;
	int   cycle_count = 0;
	int   blocks_done = 0;
	logic expect_read = 1'b0;
	logic seen_a = 1'b0;
	logic seen_b = 1'b0;

	gbx_ctrl_top #(.FF_TAP_CYCLES(64)) uut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	////////////////////////////////////////////////////////////////////////////
	// Helpers

	task automatic tick();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("Error: %s is %h, expected %h", name, got, exp);
		end
	endtask

	// Backup RAM contents seen by the sequencer on a save
	function automatic gbx_pkg::sd_word_t ram_word(input gbx_pkg::bk_addr_t a);
		return a[15:0] ^ {a[16:2], a[0]};
	endfunction

	// Host data on a load
	function automatic gbx_pkg::sd_word_t host_word(input gbx_pkg::blk_t blk,
			input gbx_pkg::buf_addr_t w);
		return {blk ^ 8'hC3, w};
	endfunction

	function automatic gbx_pkg::sd_word_t rtc_word(input gbx_pkg::buf_addr_t w);
		case (w)
			8'd0:    return rtc_stamp[15:0];
			8'd1:    return rtc_stamp[31:16];
			8'd2:    return rtc_saved[15:0];
			8'd3:    return rtc_saved[31:16];
			8'd4:    return rtc_saved[47:32];
			default: return 16'hFFFF;
		endcase
	endfunction

	function automatic gbx_pkg::joy_t pad_to_joy(input gbx_pkg::pad_btn_t btn,
			input gbx_pkg::pad_type_t typ);
		gbx_pkg::joy_t j;
		j    = '0;
		j[0] = btn[24];
		j[1] = btn[25];
		j[2] = btn[26];
		j[3] = btn[27];
		j[4] = btn[1];
		j[5] = btn[0];
		j[6] = (typ == 8'd3 || typ == 8'd8) ? btn[6] : btn[4];
		j[7] = btn[5];
		return j;
	endfunction

	function automatic gbx_pkg::pad_type_t pick_type();
		case ($urandom_range(4, 0))
			0:       return 8'd0;
			1:       return 8'd3;
			2:       return 8'd8;
			3:       return 8'd255;
			default: return 8'($urandom);
		endcase
	endfunction

	// Drives both pads with fresh USB words, then checks the next cycle
	task automatic apply_pads(input gbx_pkg::pad_btn_t btn_a, input gbx_pkg::pad_btn_t btn_b,
			input gbx_pkg::pad_type_t type_a, input gbx_pkg::pad_type_t type_b,
			input logic en_a, input logic en_b, input logic sel);
		gbx_pkg::joy_t usb_val [4];
		gbx_pkg::joy_t exp_joy [4];
		logic          pa;
		logic          pb;
		logic          combo;
		int            k;
		for (k = 0; k < 4; k++)
			usb_val[k] = 16'($urandom);
		usb_0      = usb_val[0];
		usb_1      = usb_val[1];
		usb_2      = usb_val[2];
		usb_3      = usb_val[3];
		pad_a_btn  = btn_a;
		pad_b_btn  = btn_b;
		pad_a_type = type_a;
		pad_b_type = type_b;
		pad_a_en   = en_a;
		pad_b_en   = en_b;
		native_sel = sel;
		seen_a     = seen_a | (btn_a != '0);
		seen_b     = seen_b | (btn_b != '0);
		pa = sel && en_a && (seen_a || (type_a != 8'd0 && type_a != 8'd255));
		pb = sel && en_b && (seen_b || (type_b != 8'd0 && type_b != 8'd255));
		// USB pads take the free slots in order
		k = 0;
		if (pa) begin
			exp_joy[0] = pad_to_joy(btn_a, type_a);
		end else begin
			exp_joy[0] = usb_val[k];
			k++;
		end
		if (pb) begin
			exp_joy[1] = pad_to_joy(btn_b, type_b);
		end else begin
			exp_joy[1] = usb_val[k];
			k++;
		end
		exp_joy[2] = usb_val[k];
		exp_joy[3] = usb_val[k+1];
		combo = (btn_a[26] & btn_a[5] & btn_a[0]) | (btn_b[26] & btn_b[5] & btn_b[0]);
		tick();
		compare("joy_0", 64'(joy_0), 64'(exp_joy[0]));
		compare("joy_1", 64'(joy_1), 64'(exp_joy[1]));
		compare("joy_2", 64'(joy_2), 64'(exp_joy[2]));
		compare("joy_3", 64'(joy_3), 64'(exp_joy[3]));
		compare("osd_combo", 64'(osd_combo), 64'(combo));
	endtask

	// Button on usb_0 bit 8 with no native pads
	task automatic ff_press(input int cycles, input logic exp_held, input logic exp_after);
		usb_0 = 16'h0100;
		repeat (2) tick();
		repeat (cycles - 2) begin
			compare("ff_active", 64'(ff_active), 64'(exp_held));
			tick();
		end
		usb_0 = 16'h0000;
		repeat (3) tick();
		repeat (8) begin
			compare("ff_active", 64'(ff_active), 64'(exp_after));
			tick();
		end
	endtask

	task automatic cart_download(input logic has_save, input logic nonempty);
		cart_has_save = has_save;
		img_nonempty  = nonempty;
		img_mounted   = 1'b1;
		img_readonly  = 1'b0;
		cart_loading  = 1'b1;
		repeat (8) tick();
		cart_loading  = 1'b0;
		tick();
	endtask

	task automatic pulse_save();
		save_cmd = 1'b1;
		tick();
		save_cmd = 1'b0;
	endtask

	task automatic wait_seq_done();
		while (seq_done !== 1'b1)
			tick();
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Tests

	task automatic pad_routing();
		int i;
		gbx_pkg::pad_btn_t a;
		gbx_pkg::pad_btn_t b;
		// Type 0 and 255 count only once a button was seen
		apply_pads('0, '0, 8'd0, 8'd255, 1'b1, 1'b1, 1'b1);
		apply_pads(32'h1, '0, 8'd0, 8'd255, 1'b1, 1'b1, 1'b1);
		apply_pads('0, '0, 8'd0, 8'd255, 1'b1, 1'b1, 1'b1);
		for (i = 0; i < 40; i++) begin
			a = $urandom;
			b = $urandom;
			if ($urandom_range(3, 0) == 0)
				a = '0;
			if ($urandom_range(3, 0) == 0)
				b = '0;
			apply_pads(a, b, pick_type(), pick_type(), 1'($urandom), 1'($urandom),
				$urandom_range(7, 0) != 0);
		end
	endtask

	task automatic osd_menu_combo();
		gbx_pkg::pad_btn_t combo_bits;
		gbx_pkg::pad_btn_t btn;
		int pad;
		int drop;
		combo_bits = (32'h1 << 26) | (32'h1 << 5) | 32'h1;
		for (pad = 0; pad < 2; pad++) begin
			for (drop = 0; drop < 4; drop++) begin
				btn = (32'($urandom) & ~combo_bits) | combo_bits;
				if (drop == 1)
					btn[26] = 1'b0;
				if (drop == 2)
					btn[5] = 1'b0;
				if (drop == 3)
					btn[0] = 1'b0;
				if (pad == 0)
					apply_pads(btn, '0, 8'd1, 8'd1, 1'b1, 1'b1, 1'b1);
				else
					apply_pads('0, btn, 8'd1, 8'd1, 1'b1, 1'b1, 1'b1);
			end
		end
	endtask

	task automatic fast_forward();
		native_sel = 1'b0;
		usb_0      = 16'h0000;
		repeat (4) tick();
		ff_press(200, 1'b1, 1'b0);
		ff_press(10, 1'b1, 1'b1);
		ff_press(10, 1'b1, 1'b0);
		osd_open = 1'b1;
		ff_press(30, 1'b0, 1'b0);
		osd_open = 1'b0;
	endtask

	task automatic manual_save();
		ram_mask    = 8'd3;
		rtc_inuse   = 1'b0;
		expect_read = 1'b0;
		blocks_done = 0;
		cart_download(1'b0, 1'b0);
		repeat (10) tick();
		compare("sd_rd", 64'(sd_rd), 64'd0);
		pulse_save();
		while (sd_wr !== 1'b1)
			tick();
		repeat (20) tick();
		// Ignored while the sequencer is busy
		pulse_save();
		wait_seq_done();
		compare("blocks saved", 64'(blocks_done), 64'd4);
		repeat (30) tick();
		compare("sd_wr", 64'(sd_wr), 64'd0);
		compare("blocks saved", 64'(blocks_done), 64'd4);
	endtask

	task automatic cart_autoload();
		ram_mask    = 8'd3;
		expect_read = 1'b1;
		blocks_done = 0;
		cart_download(1'b1, 1'b0);
		wait_seq_done();
		compare("blocks loaded", 64'(blocks_done), 64'd4);
		compare("bk_loading", 64'(bk_loading), 64'd0);
	endtask

	task automatic rtc_block_transfer();
		ram_mask    = 8'd2;
		rtc_inuse   = 1'b1;
		rtc_stamp   = $urandom;
		rtc_saved   = {16'($urandom), 32'($urandom)};
		expect_read = 1'b0;
		blocks_done = 0;
		// Cart RAM write with the menu closed marks a save as pending
		cram_wr     = 1'b1;
		tick();
		cram_wr     = 1'b0;
		compare("sav_pending", 64'(sav_pending), 64'd1);
		pulse_save();
		wait_seq_done();
		compare("blocks saved", 64'(blocks_done), 64'd4);
		repeat (4) tick();
		compare("sav_pending", 64'(sav_pending), 64'd0);
		expect_read = 1'b1;
		blocks_done = 0;
		load_cmd    = 1'b1;
		tick();
		load_cmd    = 1'b0;
		wait_seq_done();
		compare("blocks loaded", 64'(blocks_done), 64'd4);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// SD host model

	assign bk_q = ram_word(bk_addr);

	initial begin : sd_host
		int                 delay;
		int                 w;
		logic               is_read;
		logic               rtc;
		gbx_pkg::blk_t      blk;
		gbx_pkg::sd_word_t  word;
		gbx_pkg::buf_addr_t addr;
		sd_ack       = 1'b0;
		sd_buff_addr = '0;
		sd_buff_wr   = 1'b0;
		sd_buff_dout = '0;
		@(negedge reset);
		forever begin
			tick();
			if (sd_rd || sd_wr) begin
				blk     = gbx_pkg::blk_t'(blocks_done);
				is_read = sd_rd;
				rtc     = blk > ram_mask;
				compare("sd_lba", 64'(sd_lba), 64'(blk));
				compare("sd_rd", 64'(sd_rd), 64'(expect_read));
				compare("sd_wr", 64'(sd_wr), 64'(!expect_read));
				delay = $urandom_range(6, 2);
				repeat (delay) tick();
				sd_ack = 1'b1;
				for (w = 0; w < 256; w++) begin
					addr         = gbx_pkg::buf_addr_t'(w);
					word         = host_word(blk, addr);
					sd_buff_addr = addr;
					sd_buff_wr   = is_read;
					sd_buff_dout = word;
					#1;
					if (is_read) begin
						compare("bk_wr", 64'(bk_wr), 64'(!rtc));
						compare("bk_rtc_wr", 64'(bk_rtc_wr), 64'(rtc));
						compare("bk_data", 64'(bk_data), 64'(word));
						if (!rtc)
							compare("bk_addr", 64'(bk_addr), 64'({1'b0, blk, addr}));
					end else begin
						compare("sd_buff_din", 64'(sd_buff_din),
							64'(rtc ? rtc_word(addr) : ram_word({1'b0, blk, addr})));
						compare("bk_wr", 64'(bk_wr), 64'd0);
						compare("bk_rtc_wr", 64'(bk_rtc_wr), 64'd0);
					end
					compare("bk_loading", 64'(bk_loading), 64'(is_read));
					tick();
				end
				sd_buff_wr = 1'b0;
				sd_ack     = 1'b0;
				blocks_done++;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Run control

	initial begin : watchdog
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clk_sys);
			cycle_count++;
		end
		$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Checks run: %0d, errors: %0d", check_count, error_count);
		$display("Test failed");
		$finish;
	end

	initial begin : main
		void'($urandom(41));
		reset         = 1'b1;
		usb_0         = '0;
		usb_1         = '0;
		usb_2         = '0;
		usb_3         = '0;
		pad_a_btn     = '0;
		pad_b_btn     = '0;
		pad_a_type    = '0;
		pad_b_type    = '0;
		pad_a_en      = 1'b0;
		pad_b_en      = 1'b0;
		native_sel    = 1'b0;
		download_busy = 1'b0;
		osd_open      = 1'b0;
		cart_loading  = 1'b0;
		img_mounted   = 1'b0;
		img_readonly  = 1'b0;
		img_nonempty  = 1'b0;
		cart_has_save = 1'b0;
		cram_wr       = 1'b0;
		autosave_en   = 1'b0;
		load_cmd      = 1'b0;
		save_cmd      = 1'b0;
		ram_mask      = '0;
		rtc_inuse     = 1'b0;
		rtc_stamp     = '0;
		rtc_saved     = '0;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		#1;
		reset = 1'b0;
		tick();
		compare("sd_rd", 64'(sd_rd), 64'd0);
		compare("sd_wr", 64'(sd_wr), 64'd0);
		compare("bk_loading", 64'(bk_loading), 64'd0);
		compare("ff_active", 64'(ff_active), 64'd0);
		compare("osd_combo", 64'(osd_combo), 64'd0);
		compare("sav_pending", 64'(sav_pending), 64'd0);
		compare("joy_0", 64'(joy_0), 64'd0);
		compare("joy_1", 64'(joy_1), 64'd0);
		compare("joy_2", 64'(joy_2), 64'd0);
		compare("joy_3", 64'(joy_3), 64'd0);
		pad_routing();
		osd_menu_combo();
		fast_forward();
		manual_save();
		cart_autoload();
		rtc_block_transfer();
		repeat (4) tick();
		$display("Checks run: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// File: hw/gbx_ctrl_top.sv
////////////////////////////////////////////////////////////////////////////
// Console glue: pad routing, fast-forward and backup RAM save/load
// Single clock domain. The SD host owns the block port pace.
////////////////////////////////////////////////////////////////////////////
`include "gbx_cfg.svh"

module gbx_ctrl_top #(
	parameter int FF_TAP_CYCLES = `GBX_FF_TAP_CYCLES
) (
	input  logic                clk_sys,
	input  logic                reset,
	// Pads
	input  gbx_pkg::joy_t       usb_0,
	input  gbx_pkg::joy_t       usb_1,
	input  gbx_pkg::joy_t       usb_2,
	input  gbx_pkg::joy_t       usb_3,
	input  gbx_pkg::pad_btn_t   pad_a_btn,
	input  gbx_pkg::pad_btn_t   pad_b_btn,
	input  gbx_pkg::pad_type_t  pad_a_type,
	input  gbx_pkg::pad_type_t  pad_b_type,
	input  logic                pad_a_en,
	input  logic                pad_b_en,
	input  logic                native_sel,
	output gbx_pkg::joy_t       joy_0,
	output gbx_pkg::joy_t       joy_1,
	output gbx_pkg::joy_t       joy_2,
	output gbx_pkg::joy_t       joy_3,
	output logic                osd_combo,
	// Fast-forward and menu
	input  logic                download_busy,
	input  logic                osd_open,
	output logic                ff_active,
	// Backup triggers
	input  logic                cart_loading,
	input  logic                img_mounted,
	input  logic                img_readonly,
	input  logic                img_nonempty,
	input  logic                cart_has_save,
	input  logic                cram_wr,
	input  logic                autosave_en,
	input  logic                load_cmd,
	input  logic                save_cmd,
	output logic                sav_pending,
	// Backup RAM and RTC
	input  gbx_pkg::blk_t       ram_mask,
	input  logic                rtc_inuse,
	input  gbx_pkg::rtc_stamp_t rtc_stamp,
	input  gbx_pkg::rtc_saved_t rtc_saved,
	input  gbx_pkg::sd_word_t   bk_q,
	output gbx_pkg::bk_addr_t   bk_addr,
	output logic                bk_wr,
	output logic                bk_rtc_wr,
	output gbx_pkg::sd_word_t   bk_data,
	output logic                bk_loading,
	output logic                seq_done,
	// SD block port
	output gbx_pkg::lba_t       sd_lba,
	output logic                sd_rd,
	output logic                sd_wr,
	input  logic                sd_ack,
	input  gbx_pkg::buf_addr_t  sd_buff_addr,
	input  logic                sd_buff_wr,
	input  gbx_pkg::sd_word_t   sd_buff_dout,
	output gbx_pkg::sd_word_t   sd_buff_din
);

	logic start_load;
	logic start_save;

	pad_router u_pads (
		.clk_sys(clk_sys), .reset(reset),
		.usb_0(usb_0), .usb_1(usb_1), .usb_2(usb_2), .usb_3(usb_3),
		.pad_a_btn(pad_a_btn), .pad_b_btn(pad_b_btn),
		.pad_a_type(pad_a_type), .pad_b_type(pad_b_type),
		.pad_a_en(pad_a_en), .pad_b_en(pad_b_en), .native_sel(native_sel),
		.joy_0(joy_0), .joy_1(joy_1), .joy_2(joy_2), .joy_3(joy_3),
		.osd_combo(osd_combo)
	);

	// Player 1 fast-forward button
	ffwd_latch #(.TAP_CYCLES(FF_TAP_CYCLES)) u_ffwd (
		.clk_sys(clk_sys), .reset(reset),
		.ff_button(joy_0[8]), .download_busy(download_busy), .osd_open(osd_open),
		.ff_active(ff_active)
	);

	backup_trigger u_trig (
		.clk_sys(clk_sys), .reset(reset),
		.cart_loading(cart_loading), .img_mounted(img_mounted),
		.img_readonly(img_readonly), .cart_has_save(cart_has_save),
		.cram_wr(cram_wr), .osd_open(osd_open), .autosave_en(autosave_en),
		.img_nonempty(img_nonempty), .load_cmd(load_cmd), .save_cmd(save_cmd),
		.seq_done(seq_done), .start_load(start_load), .start_save(start_save),
		.sav_pending(sav_pending)
	);

	backup_seq u_seq (
		.clk_sys(clk_sys), .reset(reset),
		.start_load(start_load), .start_save(start_save),
		.ram_mask(ram_mask), .rtc_inuse(rtc_inuse), .sd_ack(sd_ack),
		.sd_lba(sd_lba), .sd_rd(sd_rd), .sd_wr(sd_wr),
		.bk_loading(bk_loading), .seq_done(seq_done),
		.sd_buff_addr(sd_buff_addr), .sd_buff_wr(sd_buff_wr),
		.sd_buff_dout(sd_buff_dout), .bk_q(bk_q),
		.rtc_stamp(rtc_stamp), .rtc_saved(rtc_saved),
		.bk_addr(bk_addr), .bk_wr(bk_wr), .bk_rtc_wr(bk_rtc_wr),
		.bk_data(bk_data), .sd_buff_din(sd_buff_din)
	);

endmodule

// File: backup/backup_seq.sv
////////////////////////////////////////////////////////////////////////////
// Moves backup RAM blocks over the SD block port, one request per block
// The host paces each block with sd_ack. Starts while busy are dropped.
// With the RTC in use one extra block carries the clock state.
////////////////////////////////////////////////////////////////////////////
`include "gbx_cfg.svh"

module backup_seq (
	input  logic                clk_sys,
	input  logic                reset,
	input  logic                start_load,
	input  logic                start_save,
	input  gbx_pkg::blk_t       ram_mask,
	input  logic                rtc_inuse,
	input  logic                sd_ack,
	output gbx_pkg::lba_t       sd_lba,
	output logic                sd_rd,
	output logic                sd_wr,
	output logic                bk_loading,
	output logic                seq_done,
	input  gbx_pkg::buf_addr_t  sd_buff_addr,
	input  logic                sd_buff_wr,
	input  gbx_pkg::sd_word_t   sd_buff_dout,
	input  gbx_pkg::sd_word_t   bk_q,
	input  gbx_pkg::rtc_stamp_t rtc_stamp,
	input  gbx_pkg::rtc_saved_t rtc_saved,
	output gbx_pkg::bk_addr_t   bk_addr,
	output logic                bk_wr,
	output logic                bk_rtc_wr,
	output gbx_pkg::sd_word_t   bk_data,
	output gbx_pkg::sd_word_t   sd_buff_din
);

	gbx_pkg::seq_state_t state;
	gbx_pkg::blk_t       cur_blk;
	gbx_pkg::blk_t       last_blk;
	logic                rtc_blk;
	gbx_pkg::sd_word_t   rtc_words [`GBX_RTC_WORDS];

	assign cur_blk  = sd_lba[7:0];
	assign last_blk = rtc_inuse ? ram_mask + 8'd1 : ram_mask;
	assign rtc_blk  = cur_blk > ram_mask;

	////////////////////////////////////////////////////////////////////////////
	// Buffer routing

	// Block number in the upper address bits
	assign bk_addr   = {sd_lba[8:0], sd_buff_addr};
	assign bk_data   = sd_buff_dout;
	assign bk_wr     = ~rtc_blk & sd_buff_wr & sd_ack;
	assign bk_rtc_wr = rtc_blk & sd_buff_wr & sd_ack;

	always_comb begin
		rtc_words[0] = rtc_stamp[15:0];
		rtc_words[1] = rtc_stamp[31:16];
		rtc_words[2] = rtc_saved[15:0];
		rtc_words[3] = rtc_saved[31:16];
		rtc_words[4] = rtc_saved[47:32];
	end

	// Rest of the RTC block is padding
	always_comb begin
		if (!rtc_blk)
			sd_buff_din = bk_q;
		else if (sd_buff_addr < gbx_pkg::buf_addr_t'(`GBX_RTC_WORDS))
			sd_buff_din = rtc_words[sd_buff_addr[2:0]];
		else
			sd_buff_din = 16'hFFFF;
	end

	////////////////////////////////////////////////////////////////////////////
	// Block sequencer

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state      <= gbx_pkg::SEQ_IDLE;
			sd_lba     <= '0;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
			bk_loading <= 1'b0;
			seq_done   <= 1'b0;
		end else begin
			seq_done <= 1'b0;
			case (state)
				gbx_pkg::SEQ_IDLE: begin
					if (start_load || start_save) begin
						sd_lba     <= '0;
						sd_rd      <= start_load;
						sd_wr      <= ~start_load;
						bk_loading <= start_load;
						state      <= gbx_pkg::SEQ_REQ;
					end
				end
				// Request stays up until the host acks
				gbx_pkg::SEQ_REQ: begin
					if (sd_ack) begin
						sd_rd <= 1'b0;
						sd_wr <= 1'b0;
						state <= gbx_pkg::SEQ_ACK;
					end
				end
				// Ack low again means the block is done
				gbx_pkg::SEQ_ACK: begin
					if (!sd_ack) begin
						if (cur_blk >= last_blk) begin
							bk_loading <= 1'b0;
							seq_done   <= 1'b1;
							state      <= gbx_pkg::SEQ_IDLE;
						end else begin
							sd_lba <= sd_lba + 32'd1;
							sd_rd  <= bk_loading;
							sd_wr  <= ~bk_loading;
							state  <= gbx_pkg::SEQ_REQ;
						end
					end
				end
				default: state <= gbx_pkg::SEQ_IDLE;
			endcase
		end
	end

	a_one_request: assert property (@(posedge clk_sys) disable iff (reset)
		!(sd_rd && sd_wr));

	a_lba_stable: assert property (@(posedge clk_sys) disable iff (reset)
		(sd_rd || sd_wr) && $past(sd_rd || sd_wr) |-> $stable(sd_lba));

endmodule

// File: backup/backup_trigger.sv
////////////////////////////////////////////////////////////////////////////
// Decides when backup RAM is loaded or saved
// Backup works only when a writable image was mounted during the last
// cart download. Start pulses are single cycle.
////////////////////////////////////////////////////////////////////////////
module backup_trigger (
	input  logic clk_sys,
	input  logic reset,
	input  logic cart_loading,
	input  logic img_mounted,
	input  logic img_readonly,
	input  logic cart_has_save,
	input  logic cram_wr,
	input  logic osd_open,
	input  logic autosave_en,
	input  logic img_nonempty,
	input  logic load_cmd,
	input  logic save_cmd,
	input  logic seq_done,
	output logic start_load,
	output logic start_save,
	output logic sav_pending
);

	logic loading_q;
	logic bk_ena;
	logic new_load;
	logic load_q;
	logic save_q;
	logic sav_supported;
	logic load_req;
	logic save_req;
	logic load_edge;

	assign sav_supported = cart_has_save & bk_ena;
	assign load_req      = load_cmd | new_load;
	// Autosave waits for the menu to open
	assign save_req      = save_cmd | (sav_pending & osd_open & autosave_en);
	assign load_edge     = load_req & ~load_q;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			loading_q   <= 1'b0;
			bk_ena      <= 1'b0;
			new_load    <= 1'b0;
			sav_pending <= 1'b0;
			load_q      <= 1'b0;
			save_q      <= 1'b0;
			start_load  <= 1'b0;
			start_save  <= 1'b0;
		end else begin
			loading_q <= cart_loading;
			load_q    <= load_req;
			save_q    <= save_req;
			if (!loading_q && cart_loading)
				bk_ena <= 1'b0;
			if (cart_loading && img_mounted && !img_readonly)
				bk_ena <= 1'b1;
			if (seq_done) begin
				new_load    <= 1'b0;
				sav_pending <= 1'b0;
			end
			// End of download loads any existing save
			if (loading_q && !cart_loading && bk_ena && (cart_has_save || img_nonempty))
				new_load <= 1'b1;
			if (cram_wr && !osd_open && sav_supported)
				sav_pending <= 1'b1;
			// Load wins when both requests rise together
			start_load <= bk_ena & load_edge;
			start_save <= bk_ena & save_req & ~save_q & ~load_edge;
		end
	end

endmodule

// File: hw/ffwd_latch.sv
////////////////////////////////////////////////////////////////////////////
// Fast-forward while the button is held, or latched by a short tap
// The next press drops the latch. Presses during a download or with
// the menu open are ignored.
////////////////////////////////////////////////////////////////////////////
`include "gbx_cfg.svh"

module ffwd_latch #(
	parameter int TAP_CYCLES = `GBX_FF_TAP_CYCLES
) (
	input  logic clk_sys,
	input  logic reset,
	input  logic ff_button,
	input  logic download_busy,
	input  logic osd_open,
	output logic ff_active
);

	localparam int CNT_W = $clog2(TAP_CYCLES + 1);

	logic             press;
	logic             press_q;
	logic             ff_latch;
	logic             tap_latched;
	logic [CNT_W-1:0] hold_cnt;

	assign press = ff_button & ~download_busy & ~osd_open;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			press_q     <= 1'b0;
			ff_latch    <= 1'b0;
			tap_latched <= 1'b0;
			hold_cnt    <= '0;
			ff_active   <= 1'b0;
		end else begin
			press_q <= press;
			// Saturates at the tap limit
			if (press && hold_cnt != CNT_W'(TAP_CYCLES))
				hold_cnt <= hold_cnt + 1'b1;
			if (press && !press_q) begin
				ff_latch <= 1'b0;
				hold_cnt <= '0;
			end
			// Release after a short hold latches, unless the last one did
			if (!press && press_q) begin
				tap_latched <= 1'b0;
				if (hold_cnt < CNT_W'(TAP_CYCLES) && !tap_latched) begin
					tap_latched <= 1'b1;
					ff_latch    <= 1'b1;
				end
			end
			ff_active <= press | ff_latch;
		end
	end

	// Latch stands only while its tap is still remembered
	a_latch_from_tap: assert property (@(posedge clk_sys) disable iff (reset)
		ff_latch |-> tap_latched);

endmodule

// File: hw/pad_router.sv
////////////////////////////////////////////////////////////////////////////
// Maps the two native pads onto the joypad layout and shifts USB pads
// down to the next free player slots. Type 0 or 255 means no pad until
// a button is pressed. Outputs are registered.
////////////////////////////////////////////////////////////////////////////
`include "gbx_cfg.svh"

module pad_router (
	input  logic               clk_sys,
	input  logic               reset,
	input  gbx_pkg::joy_t      usb_0,
	input  gbx_pkg::joy_t      usb_1,
	input  gbx_pkg::joy_t      usb_2,
	input  gbx_pkg::joy_t      usb_3,
	input  gbx_pkg::pad_btn_t  pad_a_btn,
	input  gbx_pkg::pad_btn_t  pad_b_btn,
	input  gbx_pkg::pad_type_t pad_a_type,
	input  gbx_pkg::pad_type_t pad_b_type,
	input  logic               pad_a_en,
	input  logic               pad_b_en,
	input  logic               native_sel,
	output gbx_pkg::joy_t      joy_0,
	output gbx_pkg::joy_t      joy_1,
	output gbx_pkg::joy_t      joy_2,
	output gbx_pkg::joy_t      joy_3,
	output logic               osd_combo
);

	logic seen_a;
	logic seen_b;
	logic pres_a;
	logic pres_b;

	// Alternate pads have no select, so button 6 stands in
	function automatic gbx_pkg::joy_t map_pad(input gbx_pkg::pad_btn_t btn,
			input gbx_pkg::pad_type_t typ);
		logic sel_btn;
		sel_btn = (typ == `GBX_PAD_ALT_TYPE_A || typ == `GBX_PAD_ALT_TYPE_B) ? btn[6] : btn[4];
		return {8'd0, btn[5], sel_btn, btn[0], btn[1], btn[27], btn[26], btn[25], btn[24]};
	endfunction

	// Down plus start plus B opens the menu
	function automatic logic menu_combo(input gbx_pkg::pad_btn_t btn);
		return btn[26] & btn[5] & btn[0];
	endfunction

	assign pres_a = native_sel && pad_a_en &&
		((pad_a_type != 8'd0 && pad_a_type != 8'hFF) || seen_a || (|pad_a_btn));
	assign pres_b = native_sel && pad_b_en &&
		((pad_b_type != 8'd0 && pad_b_type != 8'hFF) || seen_b || (|pad_b_btn));

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			seen_a    <= 1'b0;
			seen_b    <= 1'b0;
			joy_0     <= '0;
			joy_1     <= '0;
			joy_2     <= '0;
			joy_3     <= '0;
			osd_combo <= 1'b0;
		end else begin
			seen_a    <= seen_a | (|pad_a_btn);
			seen_b    <= seen_b | (|pad_b_btn);
			osd_combo <= menu_combo(pad_a_btn) | menu_combo(pad_b_btn);
			// USB pads fill whatever slots the native pads leave
			joy_0 <= pres_a ? map_pad(pad_a_btn, pad_a_type) : usb_0;
			joy_1 <= pres_b ? map_pad(pad_b_btn, pad_b_type) : (pres_a ? usb_0 : usb_1);
			joy_2 <= (pres_a && pres_b) ? usb_0 : ((pres_a || pres_b) ? usb_1 : usb_2);
			joy_3 <= (pres_a && pres_b) ? usb_1 : ((pres_a || pres_b) ? usb_2 : usb_3);
		end
	end

endmodule

// File: common/gbx_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Shared types for the controller, fast-forward and backup RAM logic
// Joypad bit order is right, left, down, up, A, B, select, start, ffwd
////////////////////////////////////////////////////////////////////////////
package gbx_pkg;

	// Console joypad word
	typedef logic [15:0] joy_t;

	// Native pad decoded buttons and type code
	typedef logic [31:0] pad_btn_t;
	typedef logic [7:0]  pad_type_t;

	// SD block port
	typedef logic [31:0] lba_t;
	typedef logic [15:0] sd_word_t;
	typedef logic [7:0]  buf_addr_t;

	// Backup block index, also the last save RAM block
	typedef logic [7:0]  blk_t;

	// Backup RAM word address
	typedef logic [16:0] bk_addr_t;

	// RTC state kept with the save file
	typedef logic [31:0] rtc_stamp_t;
	typedef logic [47:0] rtc_saved_t;

	// Block transfer sequencer
	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_REQ,
		SEQ_ACK
	} seq_state_t;

endpackage

// File: common/gbx_cfg.svh
////////////////////////////////////////////////////////////////////////////
// Build constants for the controller glue
// The tap limit counts clk_sys cycles and is overridden per instance
// when the system clock is not 16 MHz
////////////////////////////////////////////////////////////////////////////
`ifndef GBX_CFG_SVH
`define GBX_CFG_SVH

// Longest press that still counts as a tap, 0.2 s at 16 MHz
`define GBX_FF_TAP_CYCLES 3200000

// Pad types that have no select button
`define GBX_PAD_ALT_TYPE_A 8'd3
`define GBX_PAD_ALT_TYPE_B 8'd8

// Words of RTC data in the block after save RAM
`define GBX_RTC_WORDS 5

`endif
